/* logic/fpPkg.sv */
`default_nettype none

package fpPkg;

	// ========================================
	// binary32 format
	// ========================================
	localparam int expBits  = 8;    // biased exponent field
	localparam int fracBits = 23;   // stored fraction, hidden bit not counted
	localparam int rawBits  = 32;   // upstream mantissa, msb has weight one
	localparam int expMax   = 255;  // all ones exponent, inf or nan

	// ========================================
	// rounding modes
	// ========================================
	typedef enum logic [2:0] {
		rmNearEven = 3'd0,  // ties go to even lsb
		rmZero     = 3'd1,  // truncate
		rmPosInf   = 3'd2,  // toward +inf
		rmNegInf   = 3'd3,  // toward -inf
		rmAway     = 3'd4   // ties and fractions away from zero
	} roundMode;

	// ========================================
	// stage payloads
	// ========================================

	// unnormalized result from the arithmetic block
	// exp carries two spare bits so over/underflow survives
	typedef struct packed {
		logic                      sign;
		logic signed [expBits+1:0] exp;   // may be negative or above expMax
		logic [rawBits-1:0]        mant;  // not yet normalized
		roundMode                  rm;
	} rawNum;

	// normalized intermediate, ready for rounding
	// mant is hidden bit, fraction, round bit, sticky bit
	typedef struct packed {
		logic                  sign;
		logic [expBits-1:0]    exp;   // zero marks a denormal
		logic [fracBits+2:0]   mant;
		roundMode              rm;
	} interNum;

	// ieee 754 single precision word
	typedef struct packed {
		logic                sign;
		logic [expBits-1:0]  exp;
		logic [fracBits-1:0] frac;
	} fpWord;

endpackage

`default_nettype wire

/* logic/hsStage.sv */
`timescale 1ns/1ps
`default_nettype none

module hsStage #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    arstN,
	input  logic    inReq,
	output logic    inAck,
	input  payloadT inData,
	output logic    outReq,
	input  logic    outAck,
	output payloadT outData
);

	typedef enum logic [1:0] {
		sEmpty,     // nothing held
		sCaptured,  // payload latched, outReq next cycle
		sPresent,   // outReq high, waiting for outAck
		sDrain      // outReq low, waiting for outAck to fall
	} stateT;

	stateT state;
	stateT stateNext;
	logic  take;  // accept a new item this edge

	// ack still high means the last req has not dropped yet
	assign take = inReq & ~inAck & (state == sEmpty);

	// ========================================
	// FSM
	// ========================================
	always_comb begin
		stateNext = state;
		case (state)
			sEmpty:    if (take) stateNext = sCaptured;
			sCaptured: stateNext = sPresent;
			sPresent:  if (outAck) stateNext = sDrain;
			sDrain:    if (!outAck) stateNext = sEmpty;
			default:   stateNext = sEmpty;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sEmpty;
			inAck <= 1'b0;
		end else begin
			state <= stateNext;
			if (take)
				inAck <= 1'b1;  // same edge as the payload capture
			else if (!inReq)
				inAck <= 1'b0;  // one cycle after req falls
		end
	end

	// payload register, held until the stage empties
	always_ff @(posedge clk) begin
		if (take)
			outData <= inData;
	end

	assign outReq = (state == sPresent);

endmodule

`default_nettype wire

/* logic/fpNormalize.sv */
`timescale 1ns/1ps
`default_nettype none

module fpNormalize (
	input  fpPkg::rawNum   num,
	output fpPkg::interNum norm
);
	import fpPkg::*;

	int lz;     // leading zeros in num.mant, rawBits when all zero
	int expIn;  // input exponent, sign extended
	int lsh;    // left shift toward normalized form
	int rsh;    // right shift for exponents below one

	logic [2*rawBits-1:0] ext;      // mantissa with a low half to catch shifted-out bits
	logic [rawBits-1:0]   shifted;  // aligned mantissa, msb is the hidden bit
	logic                 lost;     // anything shifted past the low end

	// ========================================
	// leading zero count
	// ========================================
	always_comb begin
		lz = rawBits;
		for (int i = 0; i < rawBits; i++) begin
			if (num.mant[i])
				lz = rawBits - 1 - i;  // highest set bit wins, loop runs upward
		end
	end

	// ========================================
	// alignment
	// ========================================
	always_comb begin
		expIn = int'($signed(num.exp));
		lsh   = 0;
		rsh   = 0;
		if (expIn >= 1) begin
			// stop the shift when the exponent reaches one
			lsh = (expIn - lz >= 1) ? lz : expIn - 1;
		end else begin
			// underflow, push right into the denormal range
			rsh = (1 - expIn > 2*rawBits - 1) ? 2*rawBits - 1 : 1 - expIn;  // cap keeps sticky
		end
		ext = {num.mant, {rawBits{1'b0}}} << lsh;  // only leading zeros leave the top
		ext = ext >> rsh;
	end

	assign shifted = ext[2*rawBits-1:rawBits];
	assign lost    = |ext[rawBits-1:0];

	// ========================================
	// pack the intermediate
	// ========================================
	always_comb begin
		norm.sign = num.sign;
		norm.rm   = num.rm;
		if (expIn == expMax) begin
			// inf or nan straight through, rounder leaves these alone
			norm.exp  = expBits'(expMax);
			norm.mant = num.mant[rawBits-1 -: fracBits+3];
		end else if (lz == rawBits) begin
			norm.exp  = '0;  // exact zero, sign kept
			norm.mant = '0;
		end else if (expIn > expMax) begin
			norm.exp  = expBits'(expMax);  // overflow goes to infinity
			norm.mant = '0;
		end else begin
			// hidden bit clear here means exponent one, i.e. denormal
			norm.exp  = shifted[rawBits-1] ? expBits'(expIn - lsh) : '0;
			norm.mant = {shifted[rawBits-1 -: fracBits+2],
				|{shifted[rawBits-fracBits-3:0], lost}};  // sticky fold
		end
	end

endmodule

`default_nettype wire

/* logic/fpRound.sv */
`timescale 1ns/1ps
`default_nettype none

module fpRound (
	input  fpPkg::interNum num,
	output fpPkg::fpWord   res
);
	import fpPkg::*;

	logic xInf;   // exponent all ones
	logic dn;     // denormal intermediate
	logic guard;  // fraction lsb, decides ties
	logic rBit;   // first bit below the lsb
	logic sBit;   // or of everything below rBit
	logic rnd;    // add one ulp

	logic [expBits+fracBits:0] sum;     // exponent, hidden bit, fraction
	logic [expBits-1:0]        expOut;

	assign xInf  = &num.exp;
	assign dn    = ~|num.exp;
	assign guard = num.mant[2];
	assign rBit  = num.mant[1];
	assign sBit  = num.mant[0];

	// ========================================
	// round decision
	// ========================================
	always_comb begin
		if (xInf) begin
			rnd = 1'b0;  // inf and nan are never rounded
		end else begin
			case (num.rm)
				rmNearEven: rnd = rBit & (guard | sBit);
				rmZero:     rnd = 1'b0;
				rmPosInf:   rnd = (rBit | sBit) & ~num.sign;
				rmNegInf:   rnd = (rBit | sBit) & num.sign;
				rmAway:     rnd = rBit | sBit;
				default:    rnd = 1'b0;  // unused encodings truncate
			endcase
		end
	end

	// one carry chain from the fraction into the exponent
	// a carry out of the hidden bit bumps the exponent, at most to expMax
	assign sum = {num.exp, num.mant[fracBits+2:2]} + (expBits+fracBits+1)'(rnd);

	// ========================================
	// result assembly
	// ========================================
	always_comb begin
		if (dn)
			expOut = {{(expBits-1){1'b0}}, sum[fracBits]};  // carry into hidden bit -> min normal
		else
			expOut = sum[expBits+fracBits -: expBits];      // hidden bit dropped
	end

	always_comb begin
		res.sign = num.sign;
		res.exp  = expOut;
		res.frac = sum[fracBits-1:0];  // a carry into expMax leaves this zero for infinity
	end

endmodule

`default_nettype wire

/* logic/fpRoundUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fpRoundUnit (
	input  logic         clk,
	input  logic         arstN,
	input  logic         inReq,
	output logic         inAck,
	input  fpPkg::rawNum inData,
	output logic         outReq,
	input  logic         outAck,
	output fpPkg::fpWord outData
);
	import fpPkg::*;

	interNum normData;   // normalizer output, follows inData
	interNum heldData;   // first stage payload
	fpWord   roundData;  // rounded word offered to the second stage
	logic    midReq;     // internal four-phase pair
	logic    midAck;

	// ========================================
	// normalize, hold
	// ========================================
	fpNormalize uNorm (
		.num  (inData),
		.norm (normData)
	);

	hsStage #(.payloadT(interNum)) uStage1 (
		.clk     (clk),
		.arstN   (arstN),
		.inReq   (inReq),
		.inAck   (inAck),
		.inData  (normData),
		.outReq  (midReq),
		.outAck  (midAck),
		.outData (heldData)
	);

	// ========================================
	// round, hold
	// ========================================
	fpRound uRound (
		.num (heldData),
		.res (roundData)
	);

	hsStage #(.payloadT(fpWord)) uStage2 (
		.clk     (clk),
		.arstN   (arstN),
		.inReq   (midReq),
		.inAck   (midAck),
		.inData  (roundData),  // stable while midReq is high
		.outReq  (outReq),
		.outAck  (outAck),
		.outData (outData)
	);

endmodule

`default_nettype wire

/* sim/fpRoundUnit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module fpRoundUnit_sva (
	input logic         clk,
	input logic         arstN,
	input logic         inReq,
	input logic         inAck,
	input fpPkg::rawNum inData,
	input logic         outReq,
	input logic         outAck,
	input fpPkg::fpWord outData
);

	// req stays up until the receiver acks
	inReqHeld: assert property (@(posedge clk) disable iff (!arstN)
		inReq && !inAck |=> inReq || inAck) else $error("inReq dropped before inAck");
	outReqHeld: assert property (@(posedge clk) disable iff (!arstN)
		outReq && !outAck |=> outReq) else $error("outReq dropped before outAck");

	// payload frozen while req is high
	inDataStable: assert property (@(posedge clk) disable iff (!arstN)
		inReq |=> !inReq || $stable(inData)) else $error("inData changed under inReq");
	outDataStable: assert property (@(posedge clk) disable iff (!arstN)
		outReq |=> !outReq || $stable(outData)) else $error("outData changed under outReq");

	// ack only falls once req is gone
	inAckFall: assert property (@(posedge clk) disable iff (!arstN)
		$fell(inAck) |-> !$past(inReq)) else $error("inAck fell while inReq high");
	outAckFall: assert property (@(posedge clk) disable iff (!arstN)
		$fell(outAck) |-> !outReq) else $error("outAck fell while outReq high");

	resetIdle: assert property (@(posedge clk) !arstN |=> !inAck && !outReq)
		else $error("handshake outputs active in reset");

endmodule

bind fpRoundUnit fpRoundUnit_sva uSva (
	.clk     (clk),
	.arstN   (arstN),
	.inReq   (inReq),
	.inAck   (inAck),
	.inData  (inData),
	.outReq  (outReq),
	.outAck  (outAck),
	.outData (outData)
);

`default_nettype wire

/* sim/fpRoundUnit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fpRoundUnit_tb;
	import fpPkg::*;

	localparam int clkPeriod  = 100;
	localparam int driveDelay = 5;   // inputs move this long after the rising edge
	localparam int maxCases   = 64;
	localparam int caseCycles = 40;  // per-case cycle budget for the watchdog

	logic  clk;
	logic  arstN;
	logic  inReq;
	logic  inAck;
	rawNum inData;
	logic  outReq;
	logic  outAck;
	fpWord outData;

	rawNum caseIn  [maxCases];
	fpWord caseExp [maxCases];
	fpWord expQ    [$];  // expected words, send order
	int    nCases;
	int    nMismatch;
	int    nOther;
	logic  loaded;  // watchdog waits for the case count

	fpRoundUnit uut (
		.clk     (clk),
		.arstN   (arstN),
		.inReq   (inReq),
		.inAck   (inAck),
		.inData  (inData),
		.outReq  (outReq),
		.outAck  (outAck),
		.outData (outData)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod/2) clk = ~clk;
	end

	// ========================================
	// case file
	// ========================================
	task automatic loadCases();
		int         fd;
		string      line;
		logic [3:0] s;
		logic [9:0] e;   // two's complement, may be out of range
		logic [31:0] m;
		logic [3:0] r;
		logic [31:0] w;
		rawNum      num;
		fd = $fopen("sim/fpRound_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/fpRound_cases.txt");
			nOther++;
			return;
		end
		nCases = 0;
		while (!$feof(fd) && nCases + 2 <= maxCases) begin
			if ($fgets(line, fd) == 0)
				break;
			if ($sscanf(line, "%h %h %h %h %h", s, e, m, r, w) == 5) begin  // comments fail here
				num.sign = s[0];
				num.exp  = e;
				num.mant = m;
				num.rm   = roundMode'(r[2:0]);
				caseIn[nCases]  = num;
				caseExp[nCases] = w;
				nCases++;
				// mirror image, rounding is symmetric in the sign
				// so the two directed modes trade places
				num.sign = ~num.sign;
				if (num.rm == rmPosInf)
					num.rm = rmNegInf;
				else if (num.rm == rmNegInf)
					num.rm = rmPosInf;
				caseIn[nCases]  = num;
				caseExp[nCases] = {~w[31], w[30:0]};  // same magnitude, other sign
				nCases++;
			end
		end
		$fclose(fd);
		if (nCases == 0) begin
			$display("no cases found in sim/fpRound_cases.txt");
			nOther++;
		end
	endtask

	// ========================================
	// checks
	// ========================================
	task automatic checkWord(input fpWord got, input fpWord want);
		if (got !== want) begin
			$display("mismatch at %0t: outData sign/exp/frac got %b/%h/%h, expected %b/%h/%h",
				$time, got.sign, got.exp, got.frac, want.sign, want.exp, want.frac);
			nMismatch++;
		end
	endtask

	task automatic checkIdle(input logic ack, input logic req, input string when);
		if (ack !== 1'b0) begin
			$display("mismatch at %0t: inAck got %b, expected 0 %s", $time, ack, when);
			nMismatch++;
		end
		if (req !== 1'b0) begin
			$display("mismatch at %0t: outReq got %b, expected 0 %s", $time, req, when);
			nMismatch++;
		end
	endtask

	// ========================================
	// handshake drivers
	// ========================================
	task automatic stepCycle();
		@(posedge clk);
		#driveDelay;  // outputs settled, safe to sample and drive
	endtask

	// source side, one full four-phase cycle per case
	task automatic sendCases();
		for (int i = 0; i < nCases; i++) begin
			inData = caseIn[i];
			expQ.push_back(caseExp[i]);
			inReq = 1'b1;
			do stepCycle(); while (!inAck);
			inReq = 1'b0;
			do stepCycle(); while (inAck);  // data may change only now
		end
	endtask

	// sink side with random stalls before each ack
	task automatic ackResults();
		int    stall;
		fpWord want;
		for (int i = 0; i < nCases; i++) begin
			do stepCycle(); while (!outReq);
			stall = int'($urandom % 4);
			repeat (stall) stepCycle();  // holds stage 2, stage 1 backs up
			if (expQ.size() == 0) begin
				$display("result at %0t arrived with no case pending", $time);
				nOther++;
			end else begin
				want = expQ.pop_front();
				checkWord(outData, want);
			end
			outAck = 1'b1;
			do stepCycle(); while (outReq);
			outAck = 1'b0;
		end
	endtask

	// watchdog, budget scales with the number of cases
	initial begin
		wait (loaded);
		#((nCases * caseCycles + 20) * clkPeriod);
		$display("timeout: results still outstanding at %0t, run stopped", $time);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int seedRet;
		seedRet   = $urandom(26414);  // seed once for the whole run
		arstN     = 1'b0;
		inReq     = 1'b0;
		inData    = '0;
		outAck    = 1'b0;
		nMismatch = 0;
		nOther    = 0;
		loaded    = 1'b0;
		loadCases();
		loaded = 1'b1;

		repeat (3) @(posedge clk);
		#driveDelay;
		checkIdle(inAck, outReq, "during reset");
		arstN = 1'b1;
		stepCycle();
		checkIdle(inAck, outReq, "after reset");

		fork
			sendCases();
			ackResults();
		join

		repeat (4) stepCycle();
		checkIdle(inAck, outReq, "after the last result");  // no extra result
		if (expQ.size() != 0) begin
			$display("%0d expected results never arrived", expQ.size());
			nOther++;
		end

		$display("%0d cases, %0d mismatches, %0d other errors", nCases, nMismatch, nOther);
		if (nMismatch == 0 && nOther == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/fpRound_cases.txt */
// sign exp(10-bit two's complement) mant expected-word, all hex, mode between mant and word
// mode 0 nearest-even, 1 zero, 2 +inf, 3 -inf, 4 away
0 07F 80000000 0 3F800000
0 081 00C00000 0 3CC00000
1 07F 00000000 0 80000000
1 09E 00000001 1 BF800000
0 07F 80000080 0 3F800000
0 07F 80000180 0 3F800002
1 07F 800000C0 0 BF800001
0 07F 800001FF 1 3F800001
0 07F 80000001 2 3F800001
1 07F 800000FF 2 BF800000
1 07F 80000001 3 BF800001
1 07F 80000080 4 BF800001
0 07F FFFFFF80 0 40000000
0 0FE FFFFFF80 2 7F800000
0 0FE FFFFFFFF 1 7F7FFFFF
1 0FF 800000FF 4 FF800000
0 0FF C00000FF 2 7FC00000
0 100 80000000 0 7F800000
0 000 80000000 0 00400000
0 3EC 80000001 2 00000005
0 005 00010000 0 00001000
0 000 FFFFFFFF 4 00800000
1 001 7FFFFFC0 0 80800000

/* files.f */
logic/fpPkg.sv
logic/hsStage.sv
logic/fpNormalize.sv
logic/fpRound.sv
logic/fpRoundUnit.sv
sim/fpRoundUnit_sva.sv
sim/fpRoundUnit_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall
TOP       := fpRoundUnit_tb
DUT       := fpRoundUnit
FILELIST  := files.f
RTL       := logic/fpPkg.sv logic/hsStage.sv logic/fpNormalize.sv \
             logic/fpRound.sv logic/fpRoundUnit.sv
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT) $(RTL)

clean:
	rm -rf $(OBJDIR) $(LOG)
